// File: all.f
+incdir+common
common/muldiv_pkg.sv
divider/int_div_iterative.sv
multiplier/int_mul_iterative.sv
logic/resp_arbiter.sv
logic/int_muldiv_unit.sv
testbench/muldiv_asserts.sv
testbench/muldiv_tb.sv

// File: common/muldiv_cfg.svh
// width settings for the integer multiply/divide unit
// shared by the package and both iterative engines

`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// operand width, one machine word
`define MULDIV_XLEN 32

// request tag width, enough ids for the consumer to match responses
`define MULDIV_TAG_W 4

`endif

// File: common/muldiv_pkg.sv
// shared types for the multiply/divide unit
// operand, result and tag words plus the request and response messages

`include "muldiv_cfg.svh"

package muldiv_pkg;

  // ----------------------------------------
  // plain vector types
  // ----------------------------------------

  // one operand word
  typedef logic [`MULDIV_XLEN-1:0] op_word_t;

  // double width result, remainder high and quotient low for divides
  typedef logic [2*`MULDIV_XLEN-1:0] result_t;

  // tag carried from request to response
  typedef logic [`MULDIV_TAG_W-1:0] tag_t;

  // function codes
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  typedef struct packed {
    muldiv_fn_t fn;
    op_word_t   a;
    op_word_t   b;
    tag_t       tag;
  } muldiv_req_t;

  typedef struct packed {
    result_t result;
    tag_t    tag;
  } muldiv_resp_t;

  // magnitude of a word, two's complement only when the operation is signed
  function automatic op_word_t word_mag(op_word_t value, logic is_signed);
    if (is_signed && value[`MULDIV_XLEN-1]) begin
      return ~value + 1'b1;
    end
    return value;
  endfunction

endpackage

// File: divider/int_div_iterative.sv
// iterative restoring divider, signed and unsigned
// one quotient bit per cycle on magnitudes, signs restored at the output
`timescale 1ns/100ps
`include "muldiv_cfg.svh"

module int_div_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import muldiv_pkg::*;

  localparam int xlen = `MULDIV_XLEN;
  localparam int cnt_w = $clog2(xlen + 1);
  // counts 0..xlen-1 are iterations, the final count is a settle cycle
  localparam logic [cnt_w-1:0] last_count = cnt_w'(xlen);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  // ----------------------------------------
  // declarations
  // ----------------------------------------

  // control
  state_t           state;
  logic [cnt_w-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             step;

  // remainder in the upper half, quotient shifting in at the bottom
  logic [2*xlen:0]  rq_reg;
  // divisor aligned with the upper half of rq_reg
  logic [2*xlen:0]  divisor_reg;
  logic             quot_neg_reg;
  logic             rem_neg_reg;
  tag_t             tag_reg;

  // combinational datapath
  logic             is_signed;
  op_word_t         a_mag;
  op_word_t         b_mag;
  logic [2*xlen:0]  rq_shift;
  logic [2*xlen:0]  rq_diff;
  op_word_t         quot_mag;
  op_word_t         rem_mag;
  op_word_t         quot_out;
  op_word_t         rem_out;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // iterate on every calc cycle except the last one
  assign step = (state == st_calc) && (count != last_count);

  // ----------------------------------------
  // control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          count <= count + 1'b1;
          if (count == last_count) begin
            state <= st_done;
          end
        end
        st_done: begin
          // hold the result until the arbiter takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // only fn_div takes magnitudes, fn_divu uses the raw bits
  assign is_signed = (req.fn == fn_div);
  assign a_mag     = word_mag(req.a, is_signed);
  assign b_mag     = word_mag(req.b, is_signed);

  // shift then trial subtract, bit 2*xlen is the borrow
  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - divisor_reg;

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg       <= {{(xlen + 1){1'b0}}, a_mag};
      divisor_reg  <= {1'b0, b_mag, {xlen{1'b0}}};
      quot_neg_reg <= is_signed & (req.a[xlen-1] ^ req.b[xlen-1]);
      rem_neg_reg  <= is_signed & req.a[xlen-1];
      tag_reg      <= req.tag;
    end else if (step) begin
      if (rq_diff[2*xlen]) begin
        // borrow, restore the shifted value and shift in a zero
        rq_reg <= {rq_shift[2*xlen:1], 1'b0};
      end else begin
        // difference fits, keep it and set the quotient bit
        rq_reg <= {rq_diff[2*xlen:1], 1'b1};
      end
    end
  end

  // ----------------------------------------
  // sign fix-up and response
  // ----------------------------------------

  assign quot_mag = rq_reg[xlen-1:0];
  assign rem_mag  = rq_reg[2*xlen-1:xlen];

  // quotient negative on differing signs, remainder follows the dividend
  assign quot_out = quot_neg_reg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg_reg ? (~rem_mag + 1'b1) : rem_mag;

  always_comb begin
    resp.result = {rem_out, quot_out};
    resp.tag    = tag_reg;
  end

endmodule

// File: logic/int_muldiv_unit.sv
// integer multiply/divide unit, top level
// steers requests by function code and merges both engines onto one response port
`timescale 1ns/100ps

module int_muldiv_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import muldiv_pkg::*;

  logic         is_mul;

  // request side of each engine
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;

  // engine responses into the arbiter
  muldiv_resp_t mul_resp;
  logic         mul_resp_val;
  logic         mul_resp_rdy;
  muldiv_resp_t div_resp;
  logic         div_resp_val;
  logic         div_resp_rdy;

  // ----------------------------------------
  // request steering
  // ----------------------------------------

  // both divide codes go to the divider
  assign is_mul      = (req.fn == fn_mul);
  assign mul_req_val = req_val & is_mul;
  assign div_req_val = req_val & ~is_mul;
  assign req_rdy     = is_mul ? mul_req_rdy : div_req_rdy;

  // ----------------------------------------
  // engines and response arbiter
  // ----------------------------------------

  int_mul_iterative mul_i (
    .clk(clk), .reset(reset),
    .req(req), .req_val(mul_req_val), .req_rdy(mul_req_rdy),
    .resp(mul_resp), .resp_val(mul_resp_val), .resp_rdy(mul_resp_rdy)
  );

  int_div_iterative div_i (
    .clk(clk), .reset(reset),
    .req(req), .req_val(div_req_val), .req_rdy(div_req_rdy),
    .resp(div_resp), .resp_val(div_resp_val), .resp_rdy(div_resp_rdy)
  );

  resp_arbiter arb_i (
    .clk(clk), .reset(reset),
    .mul_resp(mul_resp), .mul_val(mul_resp_val), .mul_rdy(mul_resp_rdy),
    .div_resp(div_resp), .div_val(div_resp_val), .div_rdy(div_resp_rdy),
    .resp(resp), .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

endmodule

// File: logic/resp_arbiter.sv
// round-robin arbiter for the shared response port
// muxes the winning engine's response, grant held across a stall
`timescale 1ns/100ps

module resp_arbiter (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_resp_t mul_resp,
  input  logic                     mul_val,
  output logic                     mul_rdy,
  input  muldiv_pkg::muldiv_resp_t div_resp,
  input  logic                     div_val,
  output logic                     div_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // engine that wins when both are valid
  // after a transfer it points at the loser, during a stall at the holder
  logic prio_div;
  logic grant_div;
  logic xfer;

  // ----------------------------------------
  // grant
  // ----------------------------------------

  always_comb begin
    if (mul_val && div_val) begin
      grant_div = prio_div;
    end else begin
      grant_div = div_val;
    end
  end

  assign resp_val = mul_val | div_val;
  assign resp     = grant_div ? div_resp : mul_resp;

  // rdy goes back to the winner only
  assign mul_rdy = resp_rdy & ~grant_div;
  assign div_rdy = resp_rdy & grant_div;

  assign xfer = resp_val & resp_rdy;

  // ----------------------------------------
  // priority register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div <= 1'b0;
    end else if (resp_val) begin
      if (xfer) begin
        // the other engine goes first next time
        prio_div <= ~grant_div;
      end else begin
        // stalled, lock the current grant
        prio_div <= grant_div;
      end
    end
  end

endmodule

// File: multiplier/int_mul_iterative.sv
// iterative shift-add multiplier for signed operands
// adds one partial product per cycle, product sign applied at the output
`timescale 1ns/100ps
`include "muldiv_cfg.svh"

module int_mul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import muldiv_pkg::*;

  localparam int xlen = `MULDIV_XLEN;
  localparam int cnt_w = $clog2(xlen + 1);
  // one extra calc cycle after the last partial product
  localparam logic [cnt_w-1:0] last_count = cnt_w'(xlen);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  // control
  state_t           state;
  logic [cnt_w-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             step;

  // multiplicand shifts left, multiplier shifts right
  result_t          mcand_reg;
  op_word_t         mplier_reg;
  result_t          acc_reg;
  logic             neg_reg;
  tag_t             tag_reg;

  // ----------------------------------------
  // handshake and FSM
  // ----------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;
  assign step     = (state == st_calc) && (count != last_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          count <= count + 1'b1;
          if (count == last_count) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      // always signed, so both operands go in as magnitudes
      mcand_reg  <= {{xlen{1'b0}}, word_mag(req.a, 1'b1)};
      mplier_reg <= word_mag(req.b, 1'b1);
      acc_reg    <= '0;
      neg_reg    <= req.a[xlen-1] ^ req.b[xlen-1];
      tag_reg    <= req.tag;
    end else if (step) begin
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // negate the magnitude product when the signs differed
  always_comb begin
    resp.result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;
    resp.tag    = tag_reg;
  end

endmodule

// File: testbench/muldiv_asserts.sv
// bound checks on the unit's response handshake and arbiter grant
`timescale 1ns/100ps

module muldiv_asserts (
  input logic                     clk,
  input logic                     reset,
  input muldiv_pkg::muldiv_resp_t resp,
  input logic                     resp_val,
  input logic                     resp_rdy,
  input logic                     mul_val,
  input logic                     mul_rdy,
  input logic                     div_val,
  input logic                     div_rdy
);

  // a stalled response keeps its val and payload until taken
  resp_hold: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp))
  ) else $error("response changed while stalled");

  // any edge with reset applied leaves the port idle
  reset_quiet: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else $error("resp_val high after a reset edge");

  // rdy reaches at most one engine, and never an idle one while the other waits
  single_grant: assert property (
    @(posedge clk) disable iff (reset)
    !(mul_rdy && div_rdy) &&
    !(mul_rdy && !mul_val && div_val) &&
    !(div_rdy && !div_val && mul_val)
  ) else $error("arbiter gave rdy to both engines or to an idle one");

endmodule

bind int_muldiv_unit muldiv_asserts asserts_i (
  .clk(clk), .reset(reset),
  .resp(resp), .resp_val(resp_val), .resp_rdy(resp_rdy),
  .mul_val(mul_resp_val), .mul_rdy(mul_resp_rdy),
  .div_val(div_resp_val), .div_rdy(div_resp_rdy)
);

// File: testbench/muldiv_tb.sv
// testbench for the integer multiply/divide unit
// directed and random operations checked against a model of the result rules
`timescale 1ns/100ps
`include "muldiv_cfg.svh"

module muldiv_tb;

  import muldiv_pkg::*;

  localparam int num_ops    = 68;
  localparam int timeout_ns = num_ops * 40 * 20 + 20000;
  localparam int num_tags   = 1 << `MULDIV_TAG_W;
  localparam logic [31:0] lfsr_seed = 32'h83b1e205;

  logic         clk;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy;

  int           cycle = 0;
  int           accept_cycle;
  int           errors;
  int           test_errors;
  int           tests_run;
  logic [31:0]  op_state;
  logic [31:0]  stall_state;
  logic         mix_done;
  // responses seen on the port, in transfer order
  muldiv_resp_t rx_q[$];
  // scoreboard of outstanding requests, indexed by tag
  result_t      exp_by_tag[num_tags];
  logic         pending[num_tags];

  int_muldiv_unit int_muldiv_unit_i (
    .clk(clk), .reset(reset),
    .req(req), .req_val(req_val), .req_rdy(req_rdy),
    .resp(resp), .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // inputs settle 2 ns after the edge, so the falling edge shows the coming transfer
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      rx_q.push_back(resp);
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    end
    return bits;
  endfunction

  // expected result straight from the result rules
  function automatic result_t model_result(muldiv_fn_t fn, op_word_t a, op_word_t b);
    logic signed [63:0] prod;
    op_word_t am;
    op_word_t bm;
    op_word_t q;
    op_word_t r;
    logic a_neg;
    logic b_neg;
    if (fn == fn_mul) begin
      prod = $signed(a) * $signed(b);
      return prod;
    end
    a_neg = (fn == fn_div) && a[31];
    b_neg = (fn == fn_div) && b[31];
    am = a_neg ? -a : a;
    bm = b_neg ? -b : b;
    // divide by zero gives all ones and the dividend as remainder
    if (bm == 0) begin
      q = '1;
      r = am;
    end else begin
      q = am / bm;
      r = am % bm;
    end
    if (a_neg != b_neg) q = -q;
    if (a_neg) r = -r;
    return {r, q};
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_true(logic cond, string what);
    assert (cond === 1'b1) else begin
      $display("Error at %0t: %s", $time, what);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    $display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    errors      += test_errors;
    test_errors  = 0;
    tests_run++;
  endtask

  // hold the request until accepted, returns 2 ns after the accept edge
  task automatic issue(muldiv_fn_t fn, op_word_t a, op_word_t b, tag_t tag);
    logic done;
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req.tag = tag;
    req_val = 1'b1;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (req_rdy) begin
        done = 1'b1;
        accept_cycle = cycle + 1;
      end
      @(posedge clk);
      #2;
    end
    req_val = 1'b0;
  endtask

  task automatic wait_resp(output muldiv_resp_t r);
    while (rx_q.size() == 0) begin
      @(posedge clk);
      #2;
    end
    r = rx_q.pop_front();
  endtask

  // one operation on an idle unit, latency counted from the accept edge
  task automatic run_single(muldiv_fn_t fn, op_word_t a, op_word_t b, tag_t tag);
    muldiv_resp_t r;
    issue(fn, a, b, tag);
    do begin
      @(negedge clk);
    end while (resp_val !== 1'b1);
    check_value("latency", cycle - accept_cycle, `MULDIV_XLEN + 1);
    @(posedge clk);
    #2;
    wait_resp(r);
    check_value("resp.result", r.result, model_result(fn, a, b));
    check_value("resp.tag", r.tag, tag);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset();
    check_true(req_rdy, "req_rdy is not high after reset");
    check_true(!resp_val, "resp_val is not low after reset");
    finish_test("reset state");
  endtask

  task automatic test_divides();
    run_single(fn_div, 32'd100, 32'd7, 4'h1);
    run_single(fn_div, -32'sd100, 32'd7, 4'h2);
    run_single(fn_div, 32'd100, -32'sd7, 4'h3);
    run_single(fn_div, -32'sd100, -32'sd7, 4'h4);
    run_single(fn_divu, 32'hffffff9c, 32'd7, 4'h5);
    run_single(fn_divu, 32'd7, 32'd0, 4'h6);
    run_single(fn_div, -32'sd7, 32'd0, 4'h7);
    run_single(fn_div, 32'h80000000, 32'hffffffff, 4'h8);
    run_single(fn_divu, 32'h80000000, 32'hffffffff, 4'h9);
    finish_test("directed divides");
  endtask

  task automatic test_multiplies();
    op_word_t a;
    op_word_t b;
    run_single(fn_mul, 32'd3, 32'd5, 4'ha);
    run_single(fn_mul, -32'sd3, 32'd5, 4'hb);
    run_single(fn_mul, 32'h80000000, 32'h80000000, 4'hc);
    run_single(fn_mul, 32'hffffffff, 32'hffffffff, 4'hd);
    run_single(fn_mul, 32'h7fffffff, 32'h7fffffff, 4'he);
    run_single(fn_mul, 32'd0, -32'sd9, 4'hf);
    for (int i = 0; i < 8; i++) begin
      a = take_bits(op_state, 32);
      b = take_bits(op_state, 32);
      run_single(fn_mul, a, b, tag_t'(i));
    end
    finish_test("multiplies");
  endtask

  // multiply and divide in flight together, matched by tag
  task automatic test_concurrency();
    muldiv_resp_t r;
    int seen_mul;
    int seen_div;
    seen_mul = 0;
    seen_div = 0;
    issue(fn_mul, -32'sd12345, 32'd6789, 4'h3);
    issue(fn_div, 32'd1000003, -32'sd97, 4'h9);
    repeat (2) begin
      wait_resp(r);
      if (r.tag == 4'h3) begin
        seen_mul++;
        check_value("resp.result", r.result, model_result(fn_mul, -32'sd12345, 32'd6789));
      end else if (r.tag == 4'h9) begin
        seen_div++;
        check_value("resp.result", r.result, model_result(fn_div, 32'd1000003, -32'sd97));
      end else begin
        check_true(1'b0, "response carries a tag that was never sent");
      end
    end
    check_value("multiply tag count", seen_mul, 1);
    check_value("divide tag count", seen_div, 1);
    finish_test("concurrency");
  endtask

  task automatic test_back_pressure();
    muldiv_resp_t r;
    int seen[3];
    seen = '{0, 0, 0};
    resp_rdy = 1'b0;
    issue(fn_mul, 32'd77, -32'sd3, 4'h5);
    issue(fn_divu, 32'hdeadbeef, 32'd10, 4'h6);
    // both engines are done well before this
    repeat (40) @(posedge clk);
    #2;
    check_true(resp_val, "resp_val low although both engines finished");
    // the multiplier still holds its response, so it refuses a multiply
    req.fn = fn_mul;
    @(negedge clk);
    check_true(!req_rdy, "the multiplier was ready while its response waited");
    @(posedge clk);
    #2;
    // a new divide must wait for the stalled divider
    req.fn  = fn_div;
    req.a   = -32'sd500;
    req.b   = 32'd9;
    req.tag = 4'h7;
    req_val = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_true(!req_rdy, "a divide was accepted while the divider waited");
    end
    @(posedge clk);
    #2;
    resp_rdy = 1'b1;
    issue(fn_div, -32'sd500, 32'd9, 4'h7);
    repeat (3) begin
      wait_resp(r);
      case (r.tag)
        4'h5: check_value("resp.result", r.result, model_result(fn_mul, 32'd77, -32'sd3));
        4'h6: check_value("resp.result", r.result, model_result(fn_divu, 32'hdeadbeef, 32'd10));
        4'h7: check_value("resp.result", r.result, model_result(fn_div, -32'sd500, 32'd9));
        default: check_true(1'b0, "response carries a tag that was never sent");
      endcase
      if (r.tag >= 4'h5 && r.tag <= 4'h7) seen[r.tag - 4'h5]++;
    end
    foreach (seen[i]) check_value("tag count", seen[i], 1);
    repeat (5) @(posedge clk);
    #2;
    check_true(rx_q.size() == 0, "an extra response appeared after back-pressure");
    finish_test("back-pressure");
  endtask

  task automatic test_random_mix();
    muldiv_fn_t fn;
    logic [1:0] sel;
    op_word_t a;
    op_word_t b;
    tag_t tag;
    muldiv_resp_t r;
    int received;
    received = 0;
    mix_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          sel = 2'(take_bits(op_state, 2));
          fn  = (sel == 2'd3) ? fn_mul : muldiv_fn_t'(sel);
          a   = take_bits(op_state, 32);
          b   = take_bits(op_state, 32);
          // shift the divisor down now and then for small quotient bits
          b   = b >> take_bits(op_state, 5);
          tag = tag_t'(i);
          while (pending[tag]) begin
            @(posedge clk);
            #2;
          end
          exp_by_tag[tag] = model_result(fn, a, b);
          pending[tag]    = 1'b1;
          issue(fn, a, b, tag);
        end
      end
      begin
        while (received < 40) begin
          wait_resp(r);
          check_true(pending[r.tag], "response with no outstanding request for its tag");
          check_value("resp.result", r.result, exp_by_tag[r.tag]);
          pending[r.tag] = 1'b0;
          received++;
        end
        mix_done = 1'b1;
      end
      begin
        // stall about one cycle in four
        while (!mix_done) begin
          resp_rdy = (take_bits(stall_state, 2) != 2'd0);
          @(posedge clk);
          #2;
        end
        resp_rdy = 1'b1;
      end
    join
    finish_test("random mix");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    reset       = 1'b1;
    req         = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b1;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    op_state    = lfsr_seed;
    stall_state = lfsr_seed;
    foreach (pending[i]) pending[i] = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset();
    test_divides();
    test_multiplies();
    test_concurrency();
    test_back_pressure();
    test_random_mix();
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, about 40 cycles per operation plus a margin
  initial begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
